//--- bench/tb_fpadd.sv
// Testbench for fpadd_top with random stimulus, reference model, latency and handshake checks
`include "fpadd_settings.svh"

module tb_fpadd;
  timeunit 1ns;
  timeprecision 1ps;

  logic                clk_i;
  logic                rst_n_i;
  logic                beg_op_i;
  logic [`FPADD_W-1:0] data_x_i;
  logic [`FPADD_W-1:0] data_y_i;
  logic                add_subt_i;
  logic                busy_o;
  logic                ready_o;
  logic                overflow_flag_o;
  logic                underflow_flag_o;
  logic                zero_flag_o;
  logic [`FPADD_W-1:0] result_o;

  integer seed;
  int     checks;
  int     errors;
  int     errs_before;
  logic   timed_out;
  logic [31:0] x;
  logic [31:0] y;
  logic        sub;

  fpadd_top dut_i (.*);

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================

  // Returns {overflow, underflow, zero, result}
  function automatic logic [34:0] expected_result(input logic [31:0] a, input logic [31:0] b,
                                                  input logic op_sub);
    logic [30:0] big_m;
    logic [30:0] small_m;
    logic        a_gt;
    logic        esub;
    logic        sign;
    logic [25:0] big_s;
    logic [25:0] small_s;
    logic [26:0] raw;
    logic        carry;
    logic [25:0] norm;
    int          diff;
    int          e;
    int          lz;
    a_gt    = a[30:0] > b[30:0];
    big_m   = a_gt ? a[30:0] : b[30:0];
    small_m = a_gt ? b[30:0] : a[30:0];
    esub    = a[31] ^ b[31] ^ op_sub;
    sign    = a_gt ? a[31] : (b[31] ^ op_sub);
    // Alignment distance, anything past 31 is gone
    diff = int'(big_m[30:23]) - int'(small_m[30:23]);
    if (diff > 31) diff = 31;
    big_s   = {1'b1, big_m[22:0], 2'b00};
    small_s = {1'b1, small_m[22:0], 2'b00} >> diff;
    raw     = esub ? ({1'b0, big_s} - {1'b0, small_s}) : ({1'b0, big_s} + {1'b0, small_s});
    carry   = raw[26] & ~esub;
    if (carry) begin
      // One step right, carry becomes the hidden bit
      norm = {1'b1, raw[25:1]};
      e    = int'(big_m[30:23]) + 1;
    end else begin
      lz = 0;
      while (lz < 26 && !raw[25-lz]) lz++;
      norm = raw[25:0] << lz;
      e    = int'(big_m[30:23]) - lz;
    end
    if ((esub && a[30:0] == b[30:0]) || (!carry && raw[25:0] == 26'd0)) begin
      return {3'b001, 32'h0000_0000};
    end else if (e >= 255) begin
      return {3'b100, sign, 8'hff, 23'd0};
    end else if (e <= 0) begin
      return {3'b010, sign, 31'd0};
    end
    return {3'b000, sign, 8'(e), norm[24:2]};
  endfunction

  // Random normal operand, exponent in [lo, hi]
  function automatic logic [31:0] rand_normal(input int lo, input int hi);
    logic [31:0] r;
    int          e;
    e        = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    r        = $random(seed);
    r[30:23] = 8'(e);
    return r;
  endfunction

  // ==========================================================================
  // Checks
  // ==========================================================================

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // One operation with an optional second start pulse while busy
  task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic op_sub,
                        input logic inject);
    int          n;
    int          extra;
    logic [34:0] exp_v;
    if (timed_out) return;
    @(posedge clk_i);
    beg_op_i   <= 1'b1;
    data_x_i   <= a;
    data_y_i   <= b;
    add_subt_i <= op_sub;
    // Start is sampled on this edge
    @(posedge clk_i);
    beg_op_i <= 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!ready_o && n < 20) begin
      check_value("busy_o", 32'(busy_o), 32'h1);
      n++;
      if (inject && n == 2) begin
        @(posedge clk_i);
        beg_op_i   <= 1'b1;
        data_x_i   <= ~a;
        data_y_i   <= b ^ 32'h0040_0000;
        add_subt_i <= ~op_sub;
      end else if (inject && n == 3) begin
        @(posedge clk_i);
        beg_op_i <= 1'b0;
      end
      @(negedge clk_i);
    end
    if (!ready_o) begin
      $display("ready_o did not rise within 20 cycles of the start edge");
      errors++;
      timed_out = 1'b1;
      return;
    end
    check_true(n == 5, $sformatf("ready_o rose %0d cycles after start instead of 5", n));
    check_value("busy_o", 32'(busy_o), 32'h0);
    exp_v = expected_result(a, b, op_sub);
    check_value("result_o", result_o, exp_v[31:0]);
    check_value("overflow_flag_o", 32'(overflow_flag_o), 32'(exp_v[34]));
    check_value("underflow_flag_o", 32'(underflow_flag_o), 32'(exp_v[33]));
    check_value("zero_flag_o", 32'(zero_flag_o), 32'(exp_v[32]));
    // Result must hold and no second ready pulse may follow
    extra = 0;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      if (ready_o) extra++;
    end
    check_true(extra == 0, "extra ready_o pulse after the result");
    check_value("result_o held", result_o, exp_v[31:0]);
  endtask

  task automatic report_test(input string name, input int count);
    $display("test %s: %0d operations, %0d errors", name, count, errors - errs_before);
    errs_before = errors;
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    seed        = 33719;
    checks      = 0;
    errors      = 0;
    errs_before = 0;
    timed_out   = 1'b0;
    rst_n_i     = 1'b0;
    beg_op_i    = 1'b0;
    data_x_i    = '0;
    data_y_i    = '0;
    add_subt_i  = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Idle outputs after reset
    repeat (3) begin
      @(negedge clk_i);
      check_value("busy_o", 32'(busy_o), 32'h0);
      check_value("ready_o", 32'(ready_o), 32'h0);
      check_value("result_o", result_o, 32'h0);
      check_value("overflow_flag_o", 32'(overflow_flag_o), 32'h0);
      check_value("underflow_flag_o", 32'(underflow_flag_o), 32'h0);
      check_value("zero_flag_o", 32'(zero_flag_o), 32'h0);
    end
    report_test("reset", 0);

    // Mix of close and distant exponents
    for (int i = 0; i < 300; i++) begin
      x   = rand_normal(1, 254);
      sub = $random(seed);
      if ($random(seed) & 1) begin
        y = rand_normal((x[30:23] > 24) ? x[30:23] - 24 : 1,
                        (x[30:23] < 230) ? x[30:23] + 24 : 254);
      end else begin
        y = rand_normal(1, 254);
      end
      run_op(x, y, sub, 1'b0);
    end
    report_test("random", 300);

    // Exact cancellation both ways
    for (int i = 0; i < 20; i++) begin
      x = rand_normal(1, 254);
      y = (i % 2 == 0) ? x : {~x[31], x[30:0]};
      run_op(x, y, (i % 2 == 0), 1'b0);
      check_value("zero_flag_o", 32'(zero_flag_o), 32'h1);
      check_value("result_o", result_o, 32'h0);
    end
    report_test("cancel", 20);

    // Top exponent with carry gives infinity
    for (int i = 0; i < 20; i++) begin
      x     = rand_normal(254, 254);
      y     = rand_normal(254, 254);
      y[31] = x[31];
      run_op(x, y, 1'b0, 1'b0);
      check_value("overflow_flag_o", 32'(overflow_flag_o), 32'h1);
    end
    report_test("overflow", 20);

    // Near cancellation at exponent 1 falls below the range
    for (int i = 0; i < 20; i++) begin
      x     = rand_normal(1, 1);
      y     = rand_normal(1, 1);
      y[31] = x[31];
      if (y[22:0] == x[22:0]) y[0] = ~y[0];
      run_op(x, y, 1'b1, 1'b0);
      check_value("underflow_flag_o", 32'(underflow_flag_o), 32'h1);
    end
    report_test("underflow", 20);

    // Start pulse while busy must be dropped
    for (int i = 0; i < 10; i++) begin
      x = rand_normal(1, 254);
      y = rand_normal(1, 254);
      run_op(x, y, i[0], 1'b1);
    end
    report_test("busy_start", 10);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- fpadd_settings.svh
// Word, exponent and significand widths plus exponent limits of the adder
`ifndef FPADD_SETTINGS_SVH
`define FPADD_SETTINGS_SVH

// ==========================================================================
// IEEE-754 single precision layout
// ==========================================================================

// Full word width
`define FPADD_W 32

// Biased exponent width
`define FPADD_EW 8

// Stored fraction width
`define FPADD_SW 23

// ==========================================================================
// Working widths inside the datapath
// ==========================================================================

// Hidden bit, fraction and two low zero bits
`define FPADD_SWR 26

// Shift amount width, enough for 0..31
`define FPADD_EWR 5

// All-ones exponent, reserved for infinity
`define FPADD_EXP_MAX 255

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the adder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_fpadd -o Vtb_fpadd

./obj_dir/Vtb_fpadd > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: pass"
  exit 0
else
  echo "run_sim: fail"
  exit 1
fi

//--- source/barrel_shifter.sv
// Shared logarithmic shifter with input selection, aligned and normalized registers
`include "fpadd_settings.svh"

module barrel_shifter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  stage_ctl_if.dp           ctl,
  operand_if.shifter        ops,
  input  fpadd_pkg::sgf_t   sum_i,
  input  logic              sum_carry_i,
  input  fpadd_pkg::shamt_t lz_count_i,
  output fpadd_pkg::sgf_t   aligned_o,
  output fpadd_pkg::sgf_t   norm_sgf_o
);
  import fpadd_pkg::*;

  sgf_t   sh_in;
  shamt_t sh_amt;
  logic   sh_left;
  logic   sh_fill;
  sgf_t   sh_out;

  // Left shift runs through the right shifter between two reversals
  function automatic sgf_t bit_rev(input sgf_t d);
    sgf_t r;
    for (int i = 0; i < `FPADD_SWR; i++) begin
      r[i] = d[`FPADD_SWR-1-i];
    end
    return r;
  endfunction

  // Data, amount and fill per operation
  always_comb begin
    case (ctl.shift_op)
      SHIFT_NORM_LEFT: begin
        sh_in   = sum_i;
        sh_amt  = lz_count_i;
        sh_left = 1'b1;
        sh_fill = 1'b0;
      end
      SHIFT_NORM_RIGHT1: begin
        // Carry enters as the new hidden bit
        sh_in   = sum_i;
        sh_amt  = shamt_t'(1);
        sh_left = 1'b0;
        sh_fill = sum_carry_i;
      end
      default: begin
        sh_in   = ops.dmp_sgf_small;
        sh_amt  = ops.shift_amt;
        sh_left = 1'b0;
        sh_fill = 1'b0;
      end
    endcase
  end

  // Five levels, level i moves by 2**i, low bits are dropped
  always_comb begin : log_shift
    sgf_t stage;
    stage = sh_left ? bit_rev(sh_in) : sh_in;
    for (int i = 0; i < `FPADD_EWR; i++) begin
      if (sh_amt[i]) begin
        stage = (stage >> (1 << i)) |
                ({`FPADD_SWR{sh_fill}} & ~({`FPADD_SWR{1'b1}} >> (1 << i)));
      end
    end
    sh_out = sh_left ? bit_rev(stage) : stage;
  end

  // Alignment result in ST_ALIGN, normalized one in ST_NORM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aligned_o  <= '0;
      norm_sgf_o <= '0;
    end else if (ctl.load_shift) begin
      if (ctl.shift_op == SHIFT_ALIGN_RIGHT) begin
        aligned_o <= sh_out;
      end else begin
        norm_sgf_o <= sh_out;
      end
    end
  end

  assign ctl.carry_seen = sum_carry_i & ~ops.eff_sub;

endmodule

//--- source/fpadd_control.sv
// Stage sequencer FSM driving the stage enables and the start, busy and ready handshake
module fpadd_control (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      beg_op_i,
  stage_ctl_if.ctrl ctl,
  output logic      busy_o,
  output logic      ready_o
);
  import fpadd_pkg::*;

  stage_e state_q;
  stage_e state_d;
  logic   ready_q;

  // ========================================================================
  // Next state
  // ========================================================================

  // Straight walk through the stages, only ST_IDLE waits
  always_comb begin
    case (state_q)
      ST_IDLE: begin
        state_d = beg_op_i ? ST_EXP : ST_IDLE;
      end
      ST_EXP: begin
        state_d = ST_ALIGN;
      end
      ST_ALIGN: begin
        state_d = ST_SGF;
      end
      ST_SGF: begin
        state_d = ST_NORM;
      end
      ST_NORM: begin
        state_d = ST_FRMT;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // ========================================================================
  // State and ready registers
  // ========================================================================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // One cycle pulse as the result registers load
      ready_q <= (state_q == ST_FRMT);
    end
  end

  // ========================================================================
  // Stage enables
  // ========================================================================

  // Start is only taken while idle, later pulses are dropped
  assign ctl.load_in    = (state_q == ST_IDLE) && beg_op_i;
  assign ctl.load_exp   = (state_q == ST_EXP);
  assign ctl.load_shift = (state_q == ST_ALIGN) || (state_q == ST_NORM);
  assign ctl.load_sum   = (state_q == ST_SGF);
  assign ctl.load_out   = (state_q == ST_FRMT);

  // Normalization direction follows the adder carry
  always_comb begin
    if (state_q == ST_NORM) begin
      ctl.shift_op = ctl.carry_seen ? SHIFT_NORM_RIGHT1 : SHIFT_NORM_LEFT;
    end else begin
      ctl.shift_op = SHIFT_ALIGN_RIGHT;
    end
  end

  assign busy_o  = (state_q != ST_IDLE);
  assign ready_o = ready_q;

endmodule

//--- source/fpadd_if.sv
// Operand bundle from the prep stage and the stage control bundle of the sequencer

// ==========================================================================
// Swapped operands and operation flags, stable from ST_EXP to the next load
// ==========================================================================
interface operand_if;
  import fpadd_pkg::*;

  // Exponent of the larger operand
  exp_t   dmp_exp;
  // Larger and smaller significands, hidden bit restored
  sgf_t   dmp_sgf;
  sgf_t   dmp_sgf_small;
  // Exponent difference, saturated
  shamt_t shift_amt;
  logic   eff_sub;
  logic   res_sign;
  // Exact cancellation
  logic   res_zero;

  modport prep (
    output dmp_exp, dmp_sgf, dmp_sgf_small, shift_amt, eff_sub, res_sign, res_zero
  );
  modport shifter (input dmp_sgf_small, shift_amt, eff_sub);
  modport adder (input dmp_sgf, eff_sub);
  modport formatter (input dmp_exp, res_sign, res_zero);
endinterface

// ==========================================================================
// Stage enables from the sequencer, carry status back from the shifter
// ==========================================================================
interface stage_ctl_if;
  import fpadd_pkg::*;

  logic      load_in;
  logic      load_exp;
  shift_op_e shift_op;
  // Used by both ST_ALIGN and ST_NORM
  logic      load_shift;
  logic      load_sum;
  logic      load_out;
  // Adder carry under effective addition
  logic      carry_seen;

  modport ctrl (
    output load_in, load_exp, shift_op, load_shift, load_sum, load_out,
    input  carry_seen
  );
  modport dp (
    input  load_in, load_exp, shift_op, load_shift, load_sum, load_out,
    output carry_seen
  );
endinterface

//--- source/fpadd_pkg.sv
// Shared datapath types and encodings of the single precision adder
`include "fpadd_settings.svh"

package fpadd_pkg;

  // ========================================================================
  // Datapath types
  // ========================================================================

  // Complete IEEE word
  typedef logic [`FPADD_W-1:0] fp_word_t;

  // Magnitude without the sign bit
  typedef logic [`FPADD_W-2:0] mag_t;

  // Biased exponent
  typedef logic [`FPADD_EW-1:0] exp_t;

  // Exponent after normalization, two extra bits for overflow and underflow
  typedef logic signed [`FPADD_EW+1:0] exp_ext_t;

  // Working significand, hidden bit on top
  typedef logic [`FPADD_SWR-1:0] sgf_t;

  // Shifter amount
  typedef logic [`FPADD_EWR-1:0] shamt_t;

  // ========================================================================
  // Encodings
  // ========================================================================

  // Sequencer states, one per datapath stage
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXP,
    ST_ALIGN,
    ST_SGF,
    ST_NORM,
    ST_FRMT
  } stage_e;

  // Shared shifter operations
  typedef enum logic [1:0] {
    SHIFT_ALIGN_RIGHT,
    SHIFT_NORM_LEFT,
    SHIFT_NORM_RIGHT1
  } shift_op_e;

endpackage

//--- source/fpadd_top.sv
// Top level of the sequenced single precision adder with plain handshake ports
`include "fpadd_settings.svh"

module fpadd_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                beg_op_i,
  input  logic [`FPADD_W-1:0] data_x_i,
  input  logic [`FPADD_W-1:0] data_y_i,
  input  logic                add_subt_i,
  output logic                busy_o,
  output logic                ready_o,
  output logic                overflow_flag_o,
  output logic                underflow_flag_o,
  output logic                zero_flag_o,
  output logic [`FPADD_W-1:0] result_o
);

  // Datapath links between stages
  logic [`FPADD_SWR-1:0] aligned;
  logic [`FPADD_SWR-1:0] sum;
  logic                  sum_carry;
  logic [`FPADD_SWR-1:0] norm_sgf;
  logic [`FPADD_EWR-1:0] lz_count;

  operand_if   ops ();
  stage_ctl_if ctl ();

  // Sequencer, one stage per cycle
  fpadd_control u_control (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .beg_op_i (beg_op_i),
    .ctl      (ctl.ctrl),
    .busy_o   (busy_o),
    .ready_o  (ready_o)
  );

  operand_prep u_prep (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .data_x_i   (data_x_i),
    .data_y_i   (data_y_i),
    .add_subt_i (add_subt_i),
    .ctl        (ctl.dp),
    .ops        (ops.prep)
  );

  // Shifter shared by alignment and normalization
  barrel_shifter u_shifter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctl         (ctl.dp),
    .ops         (ops.shifter),
    .sum_i       (sum),
    .sum_carry_i (sum_carry),
    .lz_count_i  (lz_count),
    .aligned_o   (aligned),
    .norm_sgf_o  (norm_sgf)
  );

  sgf_adder u_adder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctl         (ctl.dp),
    .ops         (ops.adder),
    .aligned_i   (aligned),
    .sum_o       (sum),
    .sum_carry_o (sum_carry)
  );

  result_formatter u_formatter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ctl              (ctl.dp),
    .ops              (ops.formatter),
    .sum_i            (sum),
    .sum_carry_i      (sum_carry),
    .norm_sgf_i       (norm_sgf),
    .lz_count_o       (lz_count),
    .result_o         (result_o),
    .overflow_flag_o  (overflow_flag_o),
    .underflow_flag_o (underflow_flag_o),
    .zero_flag_o      (zero_flag_o)
  );

endmodule

//--- source/operand_prep.sv
// Operand capture, magnitude compare and swap, effective operation and exponent difference
`include "fpadd_settings.svh"

module operand_prep (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  fpadd_pkg::fp_word_t data_x_i,
  input  fpadd_pkg::fp_word_t data_y_i,
  input  logic                add_subt_i,
  stage_ctl_if.dp             ctl,
  operand_if.prep             ops
);
  import fpadd_pkg::*;

  // Captured inputs
  fp_word_t x_q;
  fp_word_t y_q;
  logic     sub_q;

  mag_t mag_x;
  mag_t mag_y;
  mag_t dmp;
  mag_t dmp_small;
  logic gt_xy;
  logic eq_xy;
  logic eff_sub;
  logic res_sign;
  exp_t exp_diff;

  // ========================================================================
  // Input capture on start
  // ========================================================================

  always_ff @(posedge clk_i) begin
    if (ctl.load_in) begin
      x_q   <= data_x_i;
      y_q   <= data_y_i;
      sub_q <= add_subt_i;
    end
  end

  // ========================================================================
  // Compare and swap
  // ========================================================================

  assign mag_x = x_q[`FPADD_W-2:0];
  assign mag_y = y_q[`FPADD_W-2:0];
  assign gt_xy = (mag_x > mag_y);
  assign eq_xy = (mag_x == mag_y);

  // Larger magnitude goes to dmp, Y wins ties
  assign dmp       = gt_xy ? mag_x : mag_y;
  assign dmp_small = gt_xy ? mag_y : mag_x;

  // Differing signs flip the requested operation
  assign eff_sub = x_q[`FPADD_W-1] ^ y_q[`FPADD_W-1] ^ sub_q;

  // Exact cancellation is +0, else sign of the larger operand
  always_comb begin
    if (eff_sub && eq_xy) begin
      res_sign = 1'b0;
    end else if (gt_xy) begin
      res_sign = x_q[`FPADD_W-1];
    end else begin
      res_sign = y_q[`FPADD_W-1] ^ sub_q;
    end
  end

  // dmp exponent is never below the smaller one
  assign exp_diff = dmp[`FPADD_W-2:`FPADD_SW] - dmp_small[`FPADD_W-2:`FPADD_SW];

  // ========================================================================
  // Stage registers, held until the next operation
  // ========================================================================

  always_ff @(posedge clk_i) begin
    if (ctl.load_exp) begin
      ops.dmp_exp       <= dmp[`FPADD_W-2:`FPADD_SW];
      ops.dmp_sgf       <= {1'b1, dmp[`FPADD_SW-1:0], 2'b00};
      ops.dmp_sgf_small <= {1'b1, dmp_small[`FPADD_SW-1:0], 2'b00};
      // Beyond 31 everything shifts out anyway
      ops.shift_amt     <= (|exp_diff[`FPADD_EW-1:`FPADD_EWR]) ? '1
                                                                : exp_diff[`FPADD_EWR-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ops.eff_sub  <= 1'b0;
      ops.res_sign <= 1'b0;
      ops.res_zero <= 1'b0;
    end else if (ctl.load_exp) begin
      ops.eff_sub  <= eff_sub;
      ops.res_sign <= res_sign;
      ops.res_zero <= eff_sub && eq_xy;
    end
  end

endmodule

//--- source/result_formatter.sv
// Leading-zero count, exponent update, range checks and IEEE packing of the result
`include "fpadd_settings.svh"

module result_formatter (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  stage_ctl_if.dp              ctl,
  operand_if.formatter         ops,
  input  fpadd_pkg::sgf_t      sum_i,
  input  logic                 sum_carry_i,
  input  fpadd_pkg::sgf_t      norm_sgf_i,
  output fpadd_pkg::shamt_t    lz_count_o,
  output fpadd_pkg::fp_word_t  result_o,
  output logic                 overflow_flag_o,
  output logic                 underflow_flag_o,
  output logic                 zero_flag_o
);
  import fpadd_pkg::*;

  shamt_t   lz_cnt;
  logic     sum_zero;
  exp_ext_t exp_base;
  exp_ext_t exp_q;
  logic     is_ovf;
  logic     is_unf;

  // ========================================================================
  // Leading-zero count of the raw sum
  // ========================================================================

  always_comb begin : lzc
    logic found;
    lz_cnt = '0;
    found  = 1'b0;
    for (int i = `FPADD_SWR-1; i >= 0; i--) begin
      if (sum_i[i]) begin
        found = 1'b1;
      end else if (!found) begin
        lz_cnt = lz_cnt + shamt_t'(1);
      end
    end
  end

  assign lz_count_o = lz_cnt;

  // A carried sum is never zero even with all low bits clear
  assign sum_zero = ~sum_carry_i & ~|sum_i;

  // ========================================================================
  // Exponent update, loaded with the normalized significand
  // ========================================================================

  assign exp_base = {2'b00, ops.dmp_exp};

  always_ff @(posedge clk_i) begin
    if (ctl.load_shift && (ctl.shift_op != SHIFT_ALIGN_RIGHT)) begin
      if (sum_carry_i) begin
        exp_q <= exp_base + exp_ext_t'(1);
      end else begin
        exp_q <= exp_base - exp_ext_t'(lz_cnt);
      end
    end
  end

  // Signed compares against the reserved exponents
  assign is_ovf = (exp_q >= exp_ext_t'(`FPADD_EXP_MAX));
  assign is_unf = (exp_q <= exp_ext_t'(0));

  // ========================================================================
  // Output packing
  // ========================================================================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_o         <= '0;
      overflow_flag_o  <= 1'b0;
      underflow_flag_o <= 1'b0;
      zero_flag_o      <= 1'b0;
    end else if (ctl.load_out) begin
      overflow_flag_o  <= 1'b0;
      underflow_flag_o <= 1'b0;
      zero_flag_o      <= 1'b0;
      if (ops.res_zero || sum_zero) begin
        // Always +0
        result_o    <= '0;
        zero_flag_o <= 1'b1;
      end else if (is_ovf) begin
        // Signed infinity
        result_o        <= {ops.res_sign, exp_t'(`FPADD_EXP_MAX), {`FPADD_SW{1'b0}}};
        overflow_flag_o <= 1'b1;
      end else if (is_unf) begin
        // Flushed to signed zero
        result_o         <= {ops.res_sign, {(`FPADD_W-1){1'b0}}};
        underflow_flag_o <= 1'b1;
      end else begin
        // Hidden bit dropped, two low zero bits dropped
        result_o <= {ops.res_sign, exp_q[`FPADD_EW-1:0], norm_sgf_i[`FPADD_SWR-2:2]};
      end
    end
  end

endmodule

//--- source/sgf_adder.sv
// Significand adder and subtractor with the sum and carry registers
`include "fpadd_settings.svh"

module sgf_adder (
  input  logic            clk_i,
  input  logic            rst_n_i,
  stage_ctl_if.dp         ctl,
  operand_if.adder        ops,
  input  fpadd_pkg::sgf_t aligned_i,
  output fpadd_pkg::sgf_t sum_o,
  output logic            sum_carry_o
);
  import fpadd_pkg::*;

  // Extra top bit for the carry
  logic [`FPADD_SWR:0] raw;

  // dmp is never below the aligned operand, so no borrow on subtract
  always_comb begin
    if (ops.eff_sub) begin
      raw = {1'b0, ops.dmp_sgf} - {1'b0, aligned_i};
    end else begin
      raw = {1'b0, ops.dmp_sgf} + {1'b0, aligned_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctl.load_sum) begin
      sum_o <= raw[`FPADD_SWR-1:0];
    end
  end

  // Carry kept for effective addition only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sum_carry_o <= 1'b0;
    end else if (ctl.load_sum) begin
      sum_carry_o <= raw[`FPADD_SWR] & ~ops.eff_sub;
    end
  end

endmodule

//--- tb.f
+incdir+.
source/fpadd_pkg.sv
source/fpadd_if.sv
source/fpadd_control.sv
source/operand_prep.sv
source/barrel_shifter.sv
source/sgf_adder.sv
source/result_formatter.sv
source/fpadd_top.sv
bench/tb_fpadd.sv
